/* rtl/scan_link_pkg.sv */
package scan_link_pkg;

    // record layout, sample above the channel tag
    localparam int SAMPLE_WIDTH = 32;
    localparam int TAG_WIDTH    = 16;
    localparam int RECORD_WIDTH = SAMPLE_WIDTH + TAG_WIDTH;

    // live channel and the mark fillers
    localparam logic [TAG_WIDTH-1:0] CHANNEL_TAG = 16'h0002;
    localparam logic [TAG_WIDTH-1:0] LINE_MARK   = 16'h000D;
    localparam logic [TAG_WIDTH-1:0] FRAME_MARK  = 16'h000E;

    // sample taken on the third held cycle
    localparam int SETTLE_COUNT = 2;
    localparam int SETTLE_WIDTH = $clog2(SETTLE_COUNT + 1);

    // record queue, 16 entries
    localparam int FIFO_ADDR_WIDTH = 4;
    localparam int FIFO_DEPTH      = 1 << FIFO_ADDR_WIDTH;

    // uart timing, kept short for simulation
    localparam int CLKS_PER_BIT     = 8;
    localparam int BIT_CNT_WIDTH    = $clog2(CLKS_PER_BIT);
    localparam int BYTES_PER_RECORD = RECORD_WIDTH / 8;
    localparam int BYTE_CNT_WIDTH   = $clog2(BYTES_PER_RECORD);

    // event picked by the encoder in a cycle
    typedef enum logic [1:0] {
        KIND_NONE,
        KIND_SAMPLE,
        KIND_FRAME,
        KIND_LINE
    } record_kind_e;

    // byte transmitter states
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

endpackage

/* rtl/scan_event_encoder.sv */
`timescale 1ns/1ps

module scan_event_encoder
    import scan_link_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [SAMPLE_WIDTH-1:0] tdc_sample,
    input  logic                    sample_valid,
    input  logic                    new_line,
    input  logic                    new_frame,
    output logic                    sample_done,
    output logic                    line_done,
    output logic                    frame_done,
    output logic                    rec_wr,
    output logic [RECORD_WIDTH-1:0] rec_data
);

    record_kind_e            kind;
    logic [SETTLE_WIDTH-1:0] settle_cnt;
    logic [RECORD_WIDTH-1:0] rec_next;

    // priority pick, a held sample request blocks both marks
    always_comb begin
        kind = KIND_NONE;
        if (sample_valid) begin
            // wait out the settle count first
            if (settle_cnt == SETTLE_WIDTH'(SETTLE_COUNT)) begin
                kind = KIND_SAMPLE;
            end
        end else if (new_frame) begin
            kind = KIND_FRAME;
        end else if (new_line) begin
            kind = KIND_LINE;
        end
    end

    // done strobes straight from the pick, same cycle
    assign sample_done = (kind == KIND_SAMPLE);
    assign frame_done  = (kind == KIND_FRAME);
    assign line_done   = (kind == KIND_LINE);

    // record image for the picked event
    always_comb begin
        case (kind)
            KIND_SAMPLE: rec_next = {tdc_sample, CHANNEL_TAG};
            KIND_FRAME:  rec_next = {FRAME_MARK, FRAME_MARK, CHANNEL_TAG};
            KIND_LINE:   rec_next = {LINE_MARK, LINE_MARK, CHANNEL_TAG};
            default:     rec_next = '0;
        endcase
    end

    // settle counter, holds while the request is low
    always_ff @(posedge clk) begin
        if (rst) begin
            settle_cnt <= '0;
        end else if (sample_valid) begin
            if (kind == KIND_SAMPLE) begin
                settle_cnt <= '0;
            end else begin
                settle_cnt <= settle_cnt + 1'b1;
            end
        end
    end

    // write strobe one cycle after acceptance
    always_ff @(posedge clk) begin
        if (rst) begin
            rec_wr <= 1'b0;
        end else begin
            rec_wr <= (kind != KIND_NONE);
        end
    end

    // payload follows the strobe
    always_ff @(posedge clk) begin
        if (kind != KIND_NONE) begin
            rec_data <= rec_next;
        end
    end

    a_done_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0({sample_done, frame_done, line_done}));

    // every accepted event becomes exactly one write, one cycle later
    a_wr_follows_done: assert property (@(posedge clk) disable iff (rst)
        (kind != KIND_NONE) |=> rec_wr);
    a_wr_has_done: assert property (@(posedge clk) disable iff (rst)
        rec_wr |-> $past(sample_done || frame_done || line_done));

endmodule

/* rtl/record_fifo.sv */
`timescale 1ns/1ps

module record_fifo
    import scan_link_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    wr_en,
    input  logic                    rd_en,
    input  logic [RECORD_WIDTH-1:0] rec_in,
    output logic [RECORD_WIDTH-1:0] rec_q,
    output logic                    fifo_empty,
    output logic                    fifo_full
);

    logic [RECORD_WIDTH-1:0] mem [FIFO_DEPTH];

    // one extra bit tells full from empty
    logic [FIFO_ADDR_WIDTH:0] wr_ptr;
    logic [FIFO_ADDR_WIDTH:0] rd_ptr;
    logic                     do_wr;
    logic                     do_rd;

    assign fifo_empty = (wr_ptr == rd_ptr);
    assign fifo_full  = (wr_ptr[FIFO_ADDR_WIDTH] != rd_ptr[FIFO_ADDR_WIDTH]) &&
                        (wr_ptr[FIFO_ADDR_WIDTH-1:0] == rd_ptr[FIFO_ADDR_WIDTH-1:0]);

    // writes into a full queue are lost
    assign do_wr = wr_en && !fifo_full;
    assign do_rd = rd_en && !fifo_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr[FIFO_ADDR_WIDTH-1:0]] <= rec_in;
        end
    end

    // registered read port, valid after the rd_en cycle
    always_ff @(posedge clk) begin
        if (do_rd) begin
            rec_q <= mem[rd_ptr[FIFO_ADDR_WIDTH-1:0]];
        end
    end

    // the drain side must look at fifo_empty before popping
    a_no_read_empty: assert property (@(posedge clk) disable iff (rst)
        rd_en |-> !fifo_empty);

endmodule

/* rtl/uart_byte_tx.sv */
`timescale 1ns/1ps

module uart_byte_tx
    import scan_link_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       byte_start,
    input  logic [7:0] byte_data,
    output logic       tx,
    output logic       byte_busy
);

    tx_state_e                state;
    logic [BIT_CNT_WIDTH-1:0] clk_cnt;
    logic [2:0]               bit_idx;
    logic [7:0]               data_sh;

    // last stop-bit clock is spent back in idle, keeps a 10-bit pitch
    assign byte_busy = (state != TX_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= TX_IDLE;
            tx      <= 1'b1;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    tx <= 1'b1;
                    if (byte_start) begin
                        // start bit goes out next cycle
                        state   <= TX_START;
                        tx      <= 1'b0;
                        clk_cnt <= '0;
                    end
                end
                TX_START: begin
                    if (clk_cnt == BIT_CNT_WIDTH'(CLKS_PER_BIT - 1)) begin
                        state   <= TX_DATA;
                        tx      <= data_sh[0];
                        clk_cnt <= '0;
                        bit_idx <= '0;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                TX_DATA: begin
                    if (clk_cnt == BIT_CNT_WIDTH'(CLKS_PER_BIT - 1)) begin
                        clk_cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= TX_STOP;
                            tx    <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= data_sh[0];
                        end
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                TX_STOP: begin
                    // one clock short, idle supplies the rest
                    if (clk_cnt == BIT_CNT_WIDTH'(CLKS_PER_BIT - 2)) begin
                        state   <= TX_IDLE;
                        clk_cnt <= '0;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // data shifter, lsb first
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && byte_start) begin
            data_sh <= byte_data;
        end else if (state != TX_IDLE && state != TX_STOP &&
                     clk_cnt == BIT_CNT_WIDTH'(CLKS_PER_BIT - 1)) begin
            data_sh <= data_sh >> 1;
        end
    end

    // the serializer must wait for idle before the next byte
    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        byte_start |-> (state == TX_IDLE));

endmodule

/* rtl/record_serializer.sv */
`timescale 1ns/1ps

module record_serializer
    import scan_link_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    fifo_empty,
    input  logic [RECORD_WIDTH-1:0] rec_q,
    output logic                    rd_en,
    output logic                    tx,
    output logic                    tx_busy
);

    logic                      launch;
    logic                      active;
    logic [BYTE_CNT_WIDTH-1:0] bytes_left;
    logic [RECORD_WIDTH-1:0]   rec_sh;
    logic                      byte_gap;
    logic                      byte_start;
    logic [7:0]                byte_data;
    logic                      byte_busy;

    // busy from the launch cycle to the end of the last stop bit
    assign tx_busy = launch | active;

    // pop only with the line free and nothing in flight
    assign rd_en = !fifo_empty && !tx_busy && !launch;

    // transmitter idle inside a record
    assign byte_gap = active && !byte_busy;

    // first byte straight from the fifo port, rest from the shifter
    assign byte_start = launch || (byte_gap && (bytes_left != '0));
    assign byte_data  = launch ? rec_q[7:0] : rec_sh[7:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            launch     <= 1'b0;
            active     <= 1'b0;
            bytes_left <= '0;
        end else begin
            launch <= rd_en;
            if (launch) begin
                active     <= 1'b1;
                bytes_left <= BYTE_CNT_WIDTH'(BYTES_PER_RECORD - 1);
            end else if (byte_gap) begin
                // last byte finished, record done
                if (bytes_left == '0) begin
                    active <= 1'b0;
                end else begin
                    bytes_left <= bytes_left - 1'b1;
                end
            end
        end
    end

    // record latched at launch, lsb byte first
    always_ff @(posedge clk) begin
        if (launch) begin
            rec_sh <= rec_q >> 8;
        end else if (byte_start) begin
            rec_sh <= rec_sh >> 8;
        end
    end

    uart_byte_tx u_byte_tx (
        .clk        (clk),
        .rst        (rst),
        .byte_start (byte_start),
        .byte_data  (byte_data),
        .tx         (tx),
        .byte_busy  (byte_busy)
    );

    a_no_pop_busy: assert property (@(posedge clk) disable iff (rst)
        !(rd_en && tx_busy));

endmodule

/* rtl/scan_link_top.sv */
`timescale 1ns/1ps

module scan_link_top
    import scan_link_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic [SAMPLE_WIDTH-1:0] tdc_sample,
    input  logic                    sample_valid,
    input  logic                    new_line,
    input  logic                    new_frame,
    output logic                    sample_done,
    output logic                    line_done,
    output logic                    frame_done,
    output logic                    tx,
    output logic                    tx_busy
);

    // encoder to queue
    logic                    rec_wr;
    logic [RECORD_WIDTH-1:0] rec_data;

    // queue to serializer
    logic [RECORD_WIDTH-1:0] rec_q;
    logic                    fifo_empty;
    logic                    rd_en;

    scan_event_encoder u_encoder (
        .clk          (clk),
        .rst          (rst),
        .tdc_sample   (tdc_sample),
        .sample_valid (sample_valid),
        .new_line     (new_line),
        .new_frame    (new_frame),
        .sample_done  (sample_done),
        .line_done    (line_done),
        .frame_done   (frame_done),
        .rec_wr       (rec_wr),
        .rec_data     (rec_data)
    );

    // full flag left open, a full queue just drops records
    record_fifo u_fifo (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (rec_wr),
        .rd_en      (rd_en),
        .rec_in     (rec_data),
        .rec_q      (rec_q),
        .fifo_empty (fifo_empty),
        .fifo_full  ()
    );

    record_serializer u_serializer (
        .clk        (clk),
        .rst        (rst),
        .fifo_empty (fifo_empty),
        .rec_q      (rec_q),
        .rd_en      (rd_en),
        .tx         (tx),
        .tx_busy    (tx_busy)
    );

endmodule

/* bench/uart_line_monitor.sv */
`timescale 1ns/1ps

module uart_line_monitor
    import scan_link_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    tx,
    output logic                    rec_valid,
    output logic [RECORD_WIDTH-1:0] rec_data,
    output logic                    stop_err
);

    logic                     active;
    logic [BIT_CNT_WIDTH-1:0] wait_cnt;
    logic [3:0]               slot;
    logic [7:0]               byte_sh;
    logic [RECORD_WIDTH-1:0]  rec_sh;
    int                       byte_cnt;

    // falling edge, half a clock away from every tx change
    always @(negedge clk) begin
        rec_valid <= 1'b0;
        stop_err  <= 1'b0;
        if (rst) begin
            active   <= 1'b0;
            byte_cnt <= 0;
        end else if (!active) begin
            // line drops, start bit begins
            if (!tx) begin
                active   <= 1'b1;
                wait_cnt <= BIT_CNT_WIDTH'(CLKS_PER_BIT / 2 - 1);
                slot     <= '0;
            end
        end else if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
        end else begin
            // middle of a bit
            wait_cnt <= BIT_CNT_WIDTH'(CLKS_PER_BIT - 1);
            slot     <= slot + 1'b1;
            if (slot == 4'd0) begin
                // line back high, false start
                if (tx) begin
                    active <= 1'b0;
                end
            end else if (slot < 4'd9) begin
                byte_sh <= {tx, byte_sh[7:1]};
            end else begin
                active   <= 1'b0;
                stop_err <= !tx;
                // bytes arrive lsb first, so shift in from the top
                if (byte_cnt == BYTES_PER_RECORD - 1) begin
                    rec_data  <= {byte_sh, rec_sh[RECORD_WIDTH-1:8]};
                    rec_valid <= 1'b1;
                    byte_cnt  <= 0;
                end else begin
                    rec_sh   <= {byte_sh, rec_sh[RECORD_WIDTH-1:8]};
                    byte_cnt <= byte_cnt + 1;
                end
            end
        end
    end

endmodule

/* bench/scan_link_tb.sv */
`timescale 1ns/1ps

module scan_link_tb
    import scan_link_pkg::*;
();

    localparam int RESET_CYCLES = 16;
    localparam int DONE_TIMEOUT = 16;
    localparam int LINE_TIMEOUT = 12 * 60 * CLKS_PER_BIT;
    localparam int BURST_EVENTS = 10;

    logic                    clk = 1'b0;
    logic                    rst;
    logic [SAMPLE_WIDTH-1:0] tdc_sample;
    logic                    sample_valid;
    logic                    new_line;
    logic                    new_frame;
    logic                    sample_done;
    logic                    line_done;
    logic                    frame_done;
    logic                    tx;
    logic                    tx_busy;
    logic [2:0]              done_bits;
    logic                    mon_valid;
    logic [RECORD_WIDTH-1:0] mon_rec;
    logic                    stop_err;
    logic [RECORD_WIDTH-1:0] exp_rec;
    logic [RECORD_WIDTH-1:0] exp_q[$];
    string                   test_name;
    int                      errors;
    int                      err_mark;
    int                      tests_run;
    int                      tests_failed;

    always #20 clk = ~clk;

    scan_link_top dut (
        .clk          (clk),
        .rst          (rst),
        .tdc_sample   (tdc_sample),
        .sample_valid (sample_valid),
        .new_line     (new_line),
        .new_frame    (new_frame),
        .sample_done  (sample_done),
        .line_done    (line_done),
        .frame_done   (frame_done),
        .tx           (tx),
        .tx_busy      (tx_busy)
    );

    uart_line_monitor u_monitor (
        .clk       (clk),
        .rst       (rst),
        .tx        (tx),
        .rec_valid (mon_valid),
        .rec_data  (mon_rec),
        .stop_err  (stop_err)
    );

    assign done_bits = {sample_done, frame_done, line_done};

    // expected record per accepted event, mid-cycle when done is settled
    always @(negedge clk) begin
        if (!rst) begin
            if (sample_done) begin
                exp_q.push_back({tdc_sample, CHANNEL_TAG});
            end
            if (frame_done) begin
                exp_q.push_back({FRAME_MARK, FRAME_MARK, CHANNEL_TAG});
            end
            if (line_done) begin
                exp_q.push_back({LINE_MARK, LINE_MARK, CHANNEL_TAG});
            end
        end
    end

    // records off the line against the expected order
    always @(posedge clk) begin
        if (mon_valid) begin
            if (exp_q.size() == 0) begin
                $display("%s: record %h arrived with none expected", test_name, mon_rec);
                errors++;
            end else begin
                exp_rec = exp_q.pop_front();
                assert (mon_rec == exp_rec) else begin
                    $display("MISMATCH %s: expected %h actual %h", test_name, exp_rec, mon_rec);
                    errors++;
                end
            end
        end
    end

    a_line_idle_high: assert property (@(posedge clk) disable iff (rst) !tx_busy |-> tx)
        else begin
            $display("%s: tx low while tx_busy is low", test_name);
            errors++;
        end

    a_done_exclusive: assert property (@(posedge clk) disable iff (rst) $onehot0(done_bits))
        else begin
            $display("%s: more than one done output high", test_name);
            errors++;
        end

    // a done bit never stays high into the next cycle
    a_done_single: assert property (@(posedge clk) disable iff (rst)
        (done_bits != 3'b000) |=> ((done_bits & $past(done_bits)) == 3'b000))
        else begin
            $display("%s: done pulse longer than one cycle", test_name);
            errors++;
        end

    a_stop_bit: assert property (@(posedge clk) disable iff (rst) !stop_err)
        else begin
            $display("%s: stop bit low on the line", test_name);
            errors++;
        end

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == err_mark) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", test_name, errors - err_mark);
        end
    endtask

    task automatic check_idle_outputs();
        assert (tx === 1'b1 && tx_busy === 1'b0 && done_bits === 3'b000) else begin
            $display("%s: outputs not idle, tx %b tx_busy %b done %b",
                     test_name, tx, tx_busy, done_bits);
            errors++;
        end
    endtask

    task automatic check_cycles(input int want, input int got);
        assert (got == want) else begin
            $display("MISMATCH %s: done cycle expected %0d actual %0d", test_name, want, got);
            errors++;
        end
    endtask

    // returns at the drive point of the cycle after the done pulse
    task automatic await_done(input logic [2:0] mask, output int cycles);
        logic [2:0] seen;
        cycles = 0;
        seen   = 3'b000;
        while (seen == 3'b000 && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            seen = done_bits;
        end
        if (seen == 3'b000) begin
            $display("%s: timed out waiting for done %b", test_name, mask);
            errors++;
        end else begin
            assert ((seen & ~mask) == 3'b000) else begin
                $display("%s: done %b fired while waiting for %b", test_name, seen, mask);
                errors++;
            end
        end
        @(posedge clk);
        #1;
    endtask

    // idle also needs every expected record to have come back
    task automatic await_line(input logic busy);
        int cycles;
        bit met;
        cycles = 0;
        met    = (tx_busy == busy) && (busy || exp_q.size() == 0);
        while (!met && cycles < LINE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            met = (tx_busy == busy) && (busy || exp_q.size() == 0);
        end
        if (!met) begin
            $display("%s: timed out waiting for tx_busy %b, %0d records outstanding",
                     test_name, busy, exp_q.size());
            errors++;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic send_event(input record_kind_e kind, input logic [SAMPLE_WIDTH-1:0] value);
        int         cycles;
        int         want;
        logic [2:0] mask;
        case (kind)
            KIND_SAMPLE: begin
                sample_valid = 1'b1;
                tdc_sample   = value;
                mask         = 3'b100;
                want         = SETTLE_COUNT + 1;
            end
            KIND_FRAME: begin
                new_frame = 1'b1;
                mask      = 3'b010;
                want      = 1;
            end
            default: begin
                new_line = 1'b1;
                mask     = 3'b001;
                want     = 1;
            end
        endcase
        await_done(mask, cycles);
        check_cycles(want, cycles);
        sample_valid = 1'b0;
        new_frame    = 1'b0;
        new_line     = 1'b0;
        // one quiet cycle so back to back marks stay separate pulses
        @(posedge clk);
        #1;
    endtask

    initial begin
        int i;
        int cycles;
        void'($urandom(52047));
        rst          = 1'b1;
        tdc_sample   = '0;
        sample_valid = 1'b0;
        new_line     = 1'b0;
        new_frame    = 1'b0;
        errors       = 0;
        err_mark     = 0;
        tests_run    = 0;
        tests_failed = 0;

        start_test("reset");
        for (i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            if (i > 0) begin
                check_idle_outputs();
            end
        end
        @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_idle_outputs();
        end
        @(posedge clk);
        #1;
        end_test();

        start_test("sample_record");
        send_event(KIND_SAMPLE, $urandom);
        await_line(1'b0);
        end_test();

        start_test("marks");
        send_event(KIND_FRAME, '0);
        send_event(KIND_LINE, '0);
        await_line(1'b0);
        end_test();

        // all three at once, sample first, then frame, then line
        start_test("priority");
        sample_valid = 1'b1;
        tdc_sample   = $urandom;
        new_frame    = 1'b1;
        new_line     = 1'b1;
        await_done(3'b100, cycles);
        check_cycles(SETTLE_COUNT + 1, cycles);
        sample_valid = 1'b0;
        await_done(3'b010, cycles);
        check_cycles(1, cycles);
        new_frame = 1'b0;
        await_done(3'b001, cycles);
        check_cycles(1, cycles);
        new_line = 1'b0;
        await_line(1'b0);
        end_test();

        // first record holds the line, the rest pile up in the queue
        start_test("queueing");
        send_event(KIND_SAMPLE, $urandom);
        await_line(1'b1);
        for (i = 1; i < BURST_EVENTS; i++) begin
            case ($urandom % 3)
                0: send_event(KIND_SAMPLE, $urandom);
                1: send_event(KIND_FRAME, '0);
                default: send_event(KIND_LINE, '0);
            endcase
        end
        await_line(1'b0);
        end_test();

        $display("tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* files.f */
rtl/scan_link_pkg.sv
rtl/scan_event_encoder.sv
rtl/record_fifo.sv
rtl/uart_byte_tx.sv
rtl/record_serializer.sv
rtl/scan_link_top.sv
bench/uart_line_monitor.sv
bench/scan_link_tb.sv
